/* filelist.f */
+incdir+hw
hw/rp_pkg.sv
hw/rp_rst_sync.sv
hw/rp_adc_capture.sv
hw/rp_dac_format.sv
hw/rp_pdm_bank.sv
hw/rp_analog_top.sv
sim/tb_rp_analog.sv

/* hw/rp_adc_capture.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_adc_capture
  import rp_pkg::*;
(
  input  logic                          adc_clk,
  input  logic                          rst_i,
  // Raw converter words without a strobe
  input  adc_raw_t [`RP_ADC_CHN-1:0]    adc_dat_i,
  // Digital loopback select per channel
  input  logic     [`RP_ADC_CHN-1:0]    mux_loop_i,
  // Held generator samples
  input  sample_t  [`RP_ADC_CHN-1:0]    loop_smp_i,
  output sample_t  [`RP_ADC_CHN-1:0]    adc_smp_o
);

  //////////////////////////////////////////////////////////////////////
  // Input register and conversion
  //////////////////////////////////////////////////////////////////////

  // Converted samples one cycle behind the pins
  sample_t [`RP_ADC_CHN-1:0] adc_smp_q;

  for (genvar i = 0; i < `RP_ADC_CHN; i++) begin : gen_ch

    // Sign bit passes straight through
    // Magnitude bits come inverted from the converter
    // Bottom two bits are padding on the 16-bit bus
    always_ff @(posedge adc_clk, posedge rst_i) begin
      if (rst_i) begin
        adc_smp_q[i] <= '0;
      end else begin
        adc_smp_q[i] <= {adc_dat_i[i][`RP_ADC_W-1], ~adc_dat_i[i][`RP_ADC_W-2:2]};
      end
    end

    //////////////////////////////////////////////////////////////////////
    // Loopback multiplexer
    //////////////////////////////////////////////////////////////////////

    // Generator sample bypasses the register without added delay
    always_comb begin
      if (mux_loop_i[i]) begin
        adc_smp_o[i] = loop_smp_i[i];
      end else begin
        adc_smp_o[i] = adc_smp_q[i];
      end
    end

    // ADC sign reaches the output one cycle after the pins
    a_sign_latency : assert property (
      @(posedge adc_clk) disable iff (rst_i)
      !$past(rst_i) && !mux_loop_i[i] |->
        adc_smp_o[i][`RP_SMP_W-1] == $past(adc_dat_i[i][`RP_ADC_W-1])
    );

  end

endmodule

/* hw/rp_analog_top.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_analog_top
  import rp_pkg::*;
(
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // ADC
  input  adc_raw_t  [`RP_ADC_CHN-1:0]    adc_dat_i,
  input  logic      [`RP_ADC_CHN-1:0]    mux_loop_i,
  output sample_t   [`RP_ADC_CHN-1:0]    adc_smp_o,
  // Generator
  input  sample_t   [`RP_ADC_CHN-1:0]    gen_dat_i,
  input  logic      [`RP_ADC_CHN-1:0]    gen_vld_i,
  // DAC
  output dac_code_t                      dac_dat_o,
  output logic                           dac_sel_o,
  output logic                           dac_rst_o,
  // PDM
  input  pdm_dens_t [`RP_PDM_CHN-1:0]    pdm_dens_i,
  output logic      [`RP_PDM_CHN-1:0]    pdm_o
);

  // Synchronized reset, active high
  logic                            rst;
  // Held generator samples for loopback
  sample_t [`RP_ADC_CHN-1:0]       loop_smp;

  //////////////////////////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////////////////////////

  rp_rst_sync u_rst_sync (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .rst_o   (rst)
  );

  // DAC chip reset follows the internal one
  assign dac_rst_o = rst;

  //////////////////////////////////////////////////////////////////////
  // DAC path
  //////////////////////////////////////////////////////////////////////

  rp_dac_format u_dac_format (
    .adc_clk    (adc_clk),
    .rst_i      (rst),
    .gen_dat_i  (gen_dat_i),
    .gen_vld_i  (gen_vld_i),
    .loop_smp_o (loop_smp),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

  //////////////////////////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////////////////////////

  rp_adc_capture u_adc_capture (
    .adc_clk    (adc_clk),
    .rst_i      (rst),
    .adc_dat_i  (adc_dat_i),
    .mux_loop_i (mux_loop_i),
    .loop_smp_i (loop_smp),
    .adc_smp_o  (adc_smp_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Slow analog outputs
  //////////////////////////////////////////////////////////////////////

  rp_pdm_bank u_pdm_bank (
    .adc_clk    (adc_clk),
    .rst_i      (rst),
    .pdm_dens_i (pdm_dens_i),
    .pdm_o      (pdm_o)
  );

endmodule

/* hw/rp_cfg.svh */
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Board channel counts
//////////////////////////////////////////////////////////////////////

// ADC inputs, also the number of generator channels
`define RP_ADC_CHN 2
// Slow analog outputs
`define RP_PDM_CHN 4

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Raw word from the ADC pins
`define RP_ADC_W   16
// Signed sample and DAC code
`define RP_SMP_W   14
// PDM density and its full-scale range
`define RP_PDM_W   8
`define RP_PDM_RNG 255

`endif

/* hw/rp_dac_format.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_dac_format
  import rp_pkg::*;
(
  input  logic                         adc_clk,
  input  logic                         rst_i,
  // Generator samples with per channel strobe
  input  sample_t [`RP_ADC_CHN-1:0]    gen_dat_i,
  input  logic    [`RP_ADC_CHN-1:0]    gen_vld_i,
  // Held samples toward the ADC loopback
  output sample_t [`RP_ADC_CHN-1:0]    loop_smp_o,
  // Shared DAC bus
  output dac_code_t                    dac_dat_o,
  output logic                         dac_sel_o
);

  //////////////////////////////////////////////////////////////////////
  // Generator sample hold
  //////////////////////////////////////////////////////////////////////

  sample_t   [`RP_ADC_CHN-1:0] gen_hold;
  dac_code_t [`RP_ADC_CHN-1:0] dac_code;

  for (genvar i = 0; i < `RP_ADC_CHN; i++) begin : gen_ch

    // Keep the last strobed sample
    always_ff @(posedge adc_clk, posedge rst_i) begin
      if (rst_i) begin
        gen_hold[i] <= '0;
      end else if (gen_vld_i[i]) begin
        gen_hold[i] <= gen_dat_i[i];
      end
    end

    // Offset code, negative slope
    // MSB kept, remaining bits inverted
    assign dac_code[i] = {gen_hold[i][`RP_SMP_W-1], ~gen_hold[i][`RP_SMP_W-2:0]};

  end

  // Loopback sees the same held value as the DAC
  assign loop_smp_o = gen_hold;

  //////////////////////////////////////////////////////////////////////
  // Two channel interleaver
  //////////////////////////////////////////////////////////////////////

  dac_phase_e phase;
  dac_phase_e phase_nxt;

  // Alternate every cycle
  always_comb begin
    if (phase == PH_CH0) begin
      phase_nxt = PH_CH1;
    end else begin
      phase_nxt = PH_CH0;
    end
  end

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      phase <= PH_CH0;
    end else begin
      phase <= phase_nxt;
    end
  end

  // Output register, code and select move together
  // Select high marks channel 0 on the bus
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      dac_dat_o <= '0;
      dac_sel_o <= 1'b0;
    end else begin
      case (phase)
        PH_CH0:  dac_dat_o <= dac_code[0];
        default: dac_dat_o <= dac_code[1];
      endcase
      dac_sel_o <= (phase == PH_CH0);
    end
  end

  // Select flips on each cycle once out of reset
  a_sel_toggles : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !$past(rst_i) |-> (dac_sel_o != $past(dac_sel_o))
  );

endmodule

/* hw/rp_pdm_bank.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_pdm_bank
  import rp_pkg::*;
(
  input  logic                           adc_clk,
  input  logic                           rst_i,
  // Density levels, one per output
  input  pdm_dens_t [`RP_PDM_CHN-1:0]    pdm_dens_i,
  output logic      [`RP_PDM_CHN-1:0]    pdm_o
);

  //////////////////////////////////////////////////////////////////////
  // First order density modulators
  //////////////////////////////////////////////////////////////////////

  // One extra bit holds the sum before wrap
  localparam int unsigned ACC_W = `RP_PDM_W + 1;
  localparam logic [ACC_W-1:0] PDM_RNG = ACC_W'(`RP_PDM_RNG);

  logic [`RP_PDM_CHN-1:0] [ACC_W-1:0] acc;
  logic [`RP_PDM_CHN-1:0] [ACC_W-1:0] acc_sum;

  for (genvar i = 0; i < `RP_PDM_CHN; i++) begin : gen_ch

    // Add density every cycle
    assign acc_sum[i] = acc[i] + ACC_W'(pdm_dens_i[i]);

    // Overflow past the range emits a pulse
    // Ones over RNG cycles equal the density
    always_ff @(posedge adc_clk, posedge rst_i) begin
      if (rst_i) begin
        acc[i]   <= '0;
        pdm_o[i] <= 1'b0;
      end else if (acc_sum[i] >= PDM_RNG) begin
        acc[i]   <= acc_sum[i] - PDM_RNG;
        pdm_o[i] <= 1'b1;
      end else begin
        acc[i]   <= acc_sum[i];
        pdm_o[i] <= 1'b0;
      end
    end

    // Residue never reaches full range
    a_acc_in_range : assert property (
      @(posedge adc_clk) disable iff (rst_i)
      acc[i] < PDM_RNG
    );

  end

endmodule

/* hw/rp_pkg.sv */
`include "rp_cfg.svh"

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Analog datapath types
  //////////////////////////////////////////////////////////////////////

  // Raw ADC word, two LSBs unused on the 14-bit converter
  typedef logic [`RP_ADC_W-1:0] adc_raw_t;

  // Two's complement sample, shared by ADC and generator
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // Offset binary DAC code with negative slope
  typedef logic [`RP_SMP_W-1:0] dac_code_t;

  // Pulse density setting
  typedef logic [`RP_PDM_W-1:0] pdm_dens_t;

  // Channel currently driven onto the shared DAC bus
  typedef enum logic {
    PH_CH0 = 1'b0,
    PH_CH1 = 1'b1
  } dac_phase_e;

endpackage

/* hw/rp_rst_sync.sv */
`timescale 1ns/1ps

module rp_rst_sync (
  input  logic adc_clk,
  input  logic top_rst,
  output logic rst_o
);

  //////////////////////////////////////////////////////////////////////
  // Reset synchronizer
  //////////////////////////////////////////////////////////////////////

  // Two stage chain, set asynchronously
  logic [1:0] rst_sync;

  // Assert at once, release after two clean edges
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rst_sync <= 2'b11;
    end else begin
      // Shift zeros in from the first stage
      rst_sync <= {rst_sync[0], 1'b0};
    end
  end

  // Last stage feeds every downstream block
  assign rst_o = rst_sync[1];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the analog datapath testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_rp_analog \
  -o tb_rp_analog > sim.log 2>&1 \
  && ./obj_dir/tb_rp_analog >> sim.log 2>&1 \
  || echo "Build or run reported an error, see sim.log"
grep -q "STATUS: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/rp_patterns.txt */
# kind adc: raw0 raw1 exp0 exp1, kind loop: sel gen0 gen1 raw
# kind dac: gen0 gen1 code0 code1, kind pdm: dens0 dens1 dens2 dens3
# ADC conversion
adc 0000 ffff 1fff 2000
adc 8000 7fff 3fff 0000
adc 1234 abcd 1b72 350c
adc 0004 c003 1ffe 2fff
adc 5a5a 0000 0969 1fff
# Digital loopback
loop 1 1fff 2000 1234
loop 2 0123 3abc 8000
loop 1 2000 0001 ffff
loop 2 0000 1fff 5a5a
# DAC codes, interleave and hold
dac 0000 1fff 1fff 0000
dac 2000 3fff 3fff 2000
dac 0123 3abc 1edc 2543
dac 1555 2aaa 0aaa 3555
# PDM densities
pdm 00 01 80 ff
pdm ff 80 01 00
pdm 40 7f c0 fe
pdm 11 22 33 aa

/* sim/tb_rp_analog.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module tb_rp_analog
  import rp_pkg::*;
();

  localparam string PAT_FILE = "sim/rp_patterns.txt";

  logic                        adc_clk;
  logic                        top_rst;
  adc_raw_t  [`RP_ADC_CHN-1:0] adc_dat_i;
  logic      [`RP_ADC_CHN-1:0] mux_loop_i;
  sample_t   [`RP_ADC_CHN-1:0] gen_dat_i;
  logic      [`RP_ADC_CHN-1:0] gen_vld_i;
  pdm_dens_t [`RP_PDM_CHN-1:0] pdm_dens_i;
  sample_t   [`RP_ADC_CHN-1:0] adc_smp_o;
  dac_code_t                   dac_dat_o;
  logic                        dac_sel_o;
  logic                        dac_rst_o;
  logic      [`RP_PDM_CHN-1:0] pdm_o;

  // Pattern store with a kind tag and four hex fields
  logic [63:0]       kind_q [$];
  logic [3:0][31:0]  fld_q [$];
  int                n_pat;
  bit                pat_loaded;
  integer            seed = 14959;

  rp_analog_top u_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference rules and checks
  //////////////////////////////////////////////////////////////////////

  // Drop the two pad bits and flip the 13 magnitude bits below the sign
  function automatic logic [`RP_SMP_W-1:0] convert_raw(input logic [`RP_ADC_W-1:0] raw);
    logic [`RP_ADC_W-1:0] shifted;
    shifted = raw >> 2;
    return shifted[`RP_SMP_W-1:0] ^ {1'b0, {(`RP_SMP_W-1){1'b1}}};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_reset_outputs();
    check_value("dac_rst_o in reset", 32'(dac_rst_o), 32'd1);
    check_value("dac_sel_o in reset", 32'(dac_sel_o), 32'd0);
    check_value("dac_dat_o in reset", 32'(dac_dat_o), 32'd0);
    check_value("pdm_o in reset", 32'(pdm_o), 32'd0);
    check_value("adc_smp_o in reset", 32'(adc_smp_o), 32'd0);
  endtask

  task automatic load_patterns();
    int               fd;
    int               code;
    logic [63:0]      kind;
    logic [3:0][31:0] fld;
    logic [8*160-1:0] rest;
    fd = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PAT_FILE);
      $display("STATUS: FAIL");
      $fatal(1, "no pattern file");
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) break;
        // Comment lines start with a lone hash
        if (kind == 64'("#")) begin
          code = $fgets(rest, fd);
        end else if (kind == 64'("adc") || kind == 64'("loop") ||
                     kind == 64'("dac") || kind == 64'("pdm")) begin
          code = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
          kind_q.push_back(kind);
          fld_q.push_back(fld);
        end else begin
          $display("Pattern file holds a line with an unknown kind tag");
          $display("STATUS: FAIL");
          $fatal(1, "bad pattern line");
        end
      end
      $fclose(fd);
      n_pat = kind_q.size();
      pat_loaded = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Converted samples appear one cycle after the raw words
  task automatic drive_adc(input logic [`RP_ADC_W-1:0] raw0, raw1,
                           input logic [`RP_SMP_W-1:0] exp0, exp1);
    @(posedge adc_clk);
    mux_loop_i   <= '0;
    adc_dat_i[0] <= raw0;
    adc_dat_i[1] <= raw1;
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("adc ch0 sample", 32'($unsigned(adc_smp_o[0])), 32'(exp0));
    check_value("adc ch1 sample", 32'($unsigned(adc_smp_o[1])), 32'(exp1));
  endtask

  task automatic run_random();
    logic [31:0] rnd0;
    logic [31:0] rnd1;
    rnd0 = $random(seed);
    rnd1 = $random(seed);
    drive_adc(rnd0[15:0], rnd1[15:0], convert_raw(rnd0[15:0]), convert_raw(rnd1[15:0]));
  endtask

  // Looped channel shows the held sample while the other shows ADC data
  task automatic run_loop(input logic [31:0] sel, g0, g1, raw);
    logic [`RP_SMP_W-1:0] exp0;
    logic [`RP_SMP_W-1:0] exp1;
    exp0 = sel[0] ? g0[13:0] : convert_raw(raw[15:0]);
    exp1 = sel[1] ? g1[13:0] : convert_raw(raw[15:0]);
    @(posedge adc_clk);
    gen_dat_i[0] <= g0[13:0];
    gen_dat_i[1] <= g1[13:0];
    gen_vld_i    <= '1;
    adc_dat_i[0] <= raw[15:0];
    adc_dat_i[1] <= raw[15:0];
    @(posedge adc_clk);
    gen_vld_i  <= '0;
    mux_loop_i <= sel[1:0];
    @(negedge adc_clk);
    check_value("loop ch0 sample", 32'($unsigned(adc_smp_o[0])), 32'(exp0));
    check_value("loop ch1 sample", 32'($unsigned(adc_smp_o[1])), 32'(exp1));
  endtask

  // Code on the bus must match the channel named by the select
  task automatic check_dac_bus(input logic [31:0] c0, c1);
    if (dac_sel_o)
      check_value("dac ch0 code", 32'(dac_dat_o), c0);
    else
      check_value("dac ch1 code", 32'(dac_dat_o), c1);
  endtask

  task automatic run_dac(input logic [31:0] g0, g1, c0, c1);
    int   k;
    logic last_sel;
    @(posedge adc_clk);
    gen_dat_i[0] <= g0[13:0];
    gen_dat_i[1] <= g1[13:0];
    gen_vld_i    <= '1;
    mux_loop_i   <= '0;
    // Hold edge then first bus edge
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check_dac_bus(c0, c1);
    last_sel = dac_sel_o;
    for (k = 0; k < 6; k++) begin
      // Strobe high for 4 edges then new data without strobe
      if (k == 1) begin
        @(posedge adc_clk);
        gen_vld_i    <= '0;
        gen_dat_i[0] <= ~g0[13:0];
        gen_dat_i[1] <= ~g1[13:0];
        mux_loop_i   <= '1;
      end
      @(negedge adc_clk);
      check_value("dac_sel_o toggle", 32'(dac_sel_o), 32'(!last_sel));
      last_sel = dac_sel_o;
      check_dac_bus(c0, c1);
      if (k >= 1) begin
        check_value("held ch0 sample", 32'($unsigned(adc_smp_o[0])), g0);
        check_value("held ch1 sample", 32'($unsigned(adc_smp_o[1])), g1);
      end
    end
  endtask

  // Ones over one full range window equal the density
  task automatic run_pdm(input logic [3:0][31:0] dens);
    int cnt [`RP_PDM_CHN];
    int j;
    int n;
    @(posedge adc_clk);
    for (j = 0; j < `RP_PDM_CHN; j++) begin
      pdm_dens_i[j] <= dens[j][7:0];
      cnt[j] = 0;
    end
    // Settling edge
    @(posedge adc_clk);
    for (n = 0; n < `RP_PDM_RNG; n++) begin
      @(negedge adc_clk);
      for (j = 0; j < `RP_PDM_CHN; j++)
        if (pdm_o[j]) cnt[j]++;
    end
    for (j = 0; j < `RP_PDM_CHN; j++)
      check_value("pdm one count", cnt[j], dens[j]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [3:0][31:0] fld;
    int               idx;
    top_rst    <= 1'b1;
    adc_dat_i  <= '0;
    mux_loop_i <= '0;
    gen_dat_i  <= '0;
    gen_vld_i  <= '0;
    pdm_dens_i <= '0;
    load_patterns();
    repeat (3) begin
      @(negedge adc_clk);
      check_reset_outputs();
    end
    @(posedge adc_clk);
    top_rst <= 1'b0;
    // Internal reset holds for two more edges
    repeat (2) begin
      @(negedge adc_clk);
      check_reset_outputs();
    end
    @(negedge adc_clk);
    check_value("dac_rst_o after release", 32'(dac_rst_o), 32'd0);
    for (idx = 0; idx < n_pat; idx++) begin
      fld = fld_q[idx];
      if (kind_q[idx] == 64'("adc"))
        drive_adc(fld[0][15:0], fld[1][15:0], fld[2][13:0], fld[3][13:0]);
      else if (kind_q[idx] == 64'("loop"))
        run_loop(fld[0], fld[1], fld[2], fld[3]);
      else if (kind_q[idx] == 64'("dac"))
        run_dac(fld[0], fld[1], fld[2], fld[3]);
      else
        run_pdm(fld);
      run_random();
    end
    $display("STATUS: PASS");
    $finish;
  end

  initial begin : watchdog
    wait (pat_loaded);
    repeat (n_pat * 300 + 500) @(posedge adc_clk);
    $display("Timed out, patterns did not finish within %0d cycles", n_pat * 300 + 500);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule
